/* source/exe_stage.sv */
`default_nettype none

module exe_stage import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	stage_bus.dst in,
	stage_bus.dst me_fwd,
	stage_bus.dst wb_fwd,
	stage_bus.src out,
	output logic redirect,
	output logic [XLEN-1:0] target_pc
);

	logic [XLEN-1:0] fwd_a, fwd_b, op_a, op_b_reg, op_b;
	logic [XLEN-1:0] hold_a, hold_b;
	logic [XLEN-1:0] alu_res, result;
	logic held;
	logic taken;

	// a load in ME has only its address, so it is skipped here
	always_comb begin
		if (me_fwd.inst_valid && me_fwd.rd_wena && !me_fwd.mem_rena &&
				me_fwd.rd_waddr == in.rs1_addr) begin
			fwd_a = me_fwd.result;
		end else if (wb_fwd.inst_valid && wb_fwd.rd_wena && wb_fwd.rd_waddr == in.rs1_addr) begin
			fwd_a = wb_fwd.result;
		end else begin
			fwd_a = in.rs1_data;
		end
		if (me_fwd.inst_valid && me_fwd.rd_wena && !me_fwd.mem_rena &&
				me_fwd.rd_waddr == in.rs2_addr) begin
			fwd_b = me_fwd.result;
		end else if (wb_fwd.inst_valid && wb_fwd.rd_wena && wb_fwd.rd_waddr == in.rs2_addr) begin
			fwd_b = wb_fwd.result;
		end else begin
			fwd_b = in.rs2_data;
		end
	end

	// WB drains during a freeze, keep the operands seen on its first cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else begin
			held <= stall;
		end
	end

	always_ff @(posedge clk) begin
		if (stall && !held) begin
			hold_a <= fwd_a;
			hold_b <= fwd_b;
		end
	end

	assign op_a = held ? hold_a : fwd_a;
	assign op_b_reg = held ? hold_b : fwd_b;
	assign op_b = (in.op2_sel == OP2_IMM) ? in.imm : op_b_reg;

	always_comb begin
		case (in.alu_op)
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR: alu_res = op_a | op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SLT: alu_res = {63'd0, $signed(op_a) < $signed(op_b)};
			default: alu_res = op_a + op_b;
		endcase
	end

	assign taken = in.inst_valid &
		((in.branch & (in.branch_ne ^ (op_a == op_b_reg))) | in.jump);
	assign redirect = taken & ~stall;
	assign target_pc = in.pc + in.imm;
	// jal links pc + 4
	assign result = in.jump ? in.pc + 64'd4 : alu_res;

	always_ff @(posedge clk) begin
		if (rst) begin
			out.inst_valid <= 1'b0;
			out.rd_wena <= 1'b0;
			out.mem_rena <= 1'b0;
			out.mem_wena <= 1'b0;
		end else if (!stall) begin
			out.inst_valid <= in.inst_valid;
			out.rd_wena <= in.rd_wena;
			out.mem_rena <= in.mem_rena;
			out.mem_wena <= in.mem_wena;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out.pc <= in.pc;
			out.inst <= in.inst;
			out.rd_waddr <= in.rd_waddr;
			out.rs2_data <= op_b_reg;
			out.result <= result;
		end
	end

	// the wrong-path instruction behind a redirect must arrive as a bubble
	assert property (@(posedge clk) disable iff (rst) redirect |=> !in.inst_valid);

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`default_nettype none

module hazard_unit import rv_pkg::*; (
	input logic [REG_AW-1:0] rs1_addr,
	input logic rs1_rena,
	input logic [REG_AW-1:0] rs2_addr,
	input logic rs2_rena,
	stage_bus.dst ex,
	input logic redirect,
	input logic mem_busy,
	output logic if_stall,
	output logic id_stall,
	output logic id_flush,
	output logic ex_stall,
	output logic me_stall
);

	logic load_use;

	// load sitting in EX whose rd is needed by ID
	assign load_use = ex.inst_valid & ex.mem_rena & ex.rd_wena &
		((rs1_rena & (rs1_addr == ex.rd_waddr)) |
		(rs2_rena & (rs2_addr == ex.rd_waddr)));

	// memory freeze wins, then redirect, then load-use
	always_comb begin
		if (mem_busy) begin
			if_stall = 1'b1;
			id_stall = 1'b1;
			id_flush = 1'b0;
			ex_stall = 1'b1;
			me_stall = 1'b1;
		end else begin
			if_stall = load_use & ~redirect;
			id_stall = 1'b0;
			id_flush = redirect | load_use;
			ex_stall = 1'b0;
			me_stall = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/id_stage.sv */
`default_nettype none

module id_stage import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input logic [XLEN-1:0] pc,
	input logic [INST_W-1:0] inst,
	input logic inst_valid,
	output logic [REG_AW-1:0] rs1_addr,
	output logic [REG_AW-1:0] rs2_addr,
	output logic rs1_rena,
	output logic rs2_rena,
	input logic [XLEN-1:0] rs1_data,
	input logic [XLEN-1:0] rs2_data,
	stage_bus.src out
);

	opcode_e opc;
	logic [2:0] funct3;
	logic [REG_AW-1:0] rd;
	logic known, writes, use1, use2;
	logic branch, branch_ne, jump, mem_rena, mem_wena;
	logic dec_valid;
	alu_op_e alu_op;
	op2_sel_e op2_sel;
	logic [XLEN-1:0] imm;

	assign opc = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rd = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign dec_valid = inst_valid & known;
	assign rs1_rena = dec_valid & use1;
	assign rs2_rena = dec_valid & use2;

	always_comb begin
		known = 1'b0;
		writes = 1'b0;
		use1 = 1'b0;
		use2 = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		mem_rena = 1'b0;
		mem_wena = 1'b0;
		alu_op = ALU_ADD;
		op2_sel = OP2_REG;
		imm = '0;
		case (opc)
			OPC_OP: begin
				known = 1'b1;
				writes = 1'b1;
				use1 = 1'b1;
				use2 = 1'b1;
				case (funct3)
					F3_ADD: alu_op = inst[30] ? ALU_SUB : ALU_ADD;
					F3_SLT: alu_op = ALU_SLT;
					F3_XOR: alu_op = ALU_XOR;
					F3_OR: alu_op = ALU_OR;
					F3_AND: alu_op = ALU_AND;
					default: known = 1'b0;
				endcase
			end
			OPC_OP_IMM, OPC_LOAD: begin
				// addi and ld share the I immediate
				known = (opc == OPC_LOAD) ? (funct3 == F3_DW) : (funct3 == F3_ADD);
				writes = 1'b1;
				use1 = 1'b1;
				mem_rena = (opc == OPC_LOAD);
				op2_sel = OP2_IMM;
				imm = {{52{inst[31]}}, inst[31:20]};
			end
			OPC_STORE: begin
				known = (funct3 == F3_DW);
				use1 = 1'b1;
				use2 = 1'b1;
				mem_wena = 1'b1;
				op2_sel = OP2_IMM;
				imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OPC_BRANCH: begin
				known = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				use1 = 1'b1;
				use2 = 1'b1;
				branch = 1'b1;
				branch_ne = funct3[0];
				imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			OPC_JAL: begin
				known = 1'b1;
				writes = 1'b1;
				jump = 1'b1;
				imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out.inst_valid <= 1'b0;
			out.inst <= NOP_INST;
			out.rd_wena <= 1'b0;
			out.branch <= 1'b0;
			out.jump <= 1'b0;
			out.mem_rena <= 1'b0;
			out.mem_wena <= 1'b0;
		end else if (!stall) begin
			if (flush || !dec_valid) begin
				out.inst_valid <= 1'b0;
				out.inst <= NOP_INST;
				out.rd_wena <= 1'b0;
				out.branch <= 1'b0;
				out.jump <= 1'b0;
				out.mem_rena <= 1'b0;
				out.mem_wena <= 1'b0;
			end else begin
				out.inst_valid <= 1'b1;
				out.inst <= inst;
				// x0 is never written
				out.rd_wena <= writes & (rd != '0);
				out.branch <= branch;
				out.jump <= jump;
				out.mem_rena <= mem_rena;
				out.mem_wena <= mem_wena;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out.pc <= pc;
			out.rd_waddr <= rd;
			out.rs1_addr <= rs1_addr;
			out.rs2_addr <= rs2_addr;
			out.rs1_data <= rs1_data;
			out.rs2_data <= rs2_data;
			out.imm <= imm;
			out.alu_op <= alu_op;
			out.op2_sel <= op2_sel;
			out.branch_ne <= branch_ne;
		end
	end

endmodule

`default_nettype wire

/* source/if_stage.sv */
`default_nettype none

module if_stage import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic if_ready,
	input logic [XLEN-1:0] if_data_read,
	output logic if_valid,
	output logic [XLEN-1:0] if_addr,
	input logic stall,
	input logic redirect,
	input logic [XLEN-1:0] target_pc,
	output logic [XLEN-1:0] pc,
	output logic [INST_W-1:0] inst,
	output logic inst_valid
);

	logic [XLEN-1:0] fetch_pc;
	logic [XLEN-1:0] redir_pc;
	logic [XLEN-1:0] hold_pc;
	logic [INST_W-1:0] hold_inst;
	logic [INST_W-1:0] fetched;
	logic req;
	logic discard;
	logic hold_valid;
	logic done;
	logic take;

	assign if_valid = req;
	assign if_addr = fetch_pc;
	assign done = req & if_ready;
	assign take = done & ~discard & ~redirect;
	// 64-bit bus, pick the word by address
	assign fetched = fetch_pc[2] ? if_data_read[63:32] : if_data_read[31:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= RESET_PC;
			req <= 1'b0;
			discard <= 1'b0;
			hold_valid <= 1'b0;
			inst_valid <= 1'b0;
			inst <= NOP_INST;
		end else if (redirect) begin
			hold_valid <= 1'b0;
			inst_valid <= 1'b0;
			inst <= NOP_INST;
			if (req & ~if_ready) begin
				// let the pending fetch finish, then go to the target
				discard <= 1'b1;
				redir_pc <= target_pc;
			end else begin
				fetch_pc <= target_pc;
				req <= 1'b1;
				discard <= 1'b0;
			end
		end else begin
			if (done) begin
				discard <= 1'b0;
				fetch_pc <= discard ? redir_pc : fetch_pc + 64'd4;
				req <= discard | ~stall;
			end else if (!req && !stall) begin
				req <= 1'b1;
			end
			if (!stall) begin
				hold_valid <= 1'b0;
				if (hold_valid) begin
					pc <= hold_pc;
					inst <= hold_inst;
					inst_valid <= 1'b1;
				end else if (take) begin
					pc <= fetch_pc;
					inst <= fetched;
					inst_valid <= 1'b1;
				end else begin
					inst <= NOP_INST;
					inst_valid <= 1'b0;
				end
			end else if (take) begin
				// IF/ID busy, park the word
				hold_valid <= 1'b1;
				hold_pc <= fetch_pc;
				hold_inst <= fetched;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		if_valid && !if_ready |=> if_valid && $stable(if_addr));

endmodule

`default_nettype wire

/* source/me_stage.sv */
`default_nettype none

module me_stage import rv_pkg::*; (
	input logic clk,
	input logic rst,
	stage_bus.dst in,
	output logic mem_valid,
	output logic mem_write,
	output logic [XLEN-1:0] mem_addr,
	output logic [XLEN-1:0] mem_data_write,
	input logic mem_ready,
	input logic [XLEN-1:0] mem_data_read,
	output logic busy,
	stage_bus.src out
);

	logic [XLEN-1:0] rd_data;

	assign mem_valid = in.inst_valid & (in.mem_rena | in.mem_wena);
	assign mem_write = in.mem_wena;
	assign mem_addr = in.result;
	assign mem_data_write = in.rs2_data;
	assign busy = mem_valid & ~mem_ready;

	// load data is taken in the ready cycle
	assign rd_data = in.mem_rena ? mem_data_read : in.result;

	always_ff @(posedge clk) begin
		if (rst || busy) begin
			out.inst_valid <= 1'b0;
			out.rd_wena <= 1'b0;
		end else begin
			out.inst_valid <= in.inst_valid;
			out.rd_wena <= in.rd_wena;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			out.pc <= in.pc;
			out.inst <= in.inst;
			out.rd_waddr <= in.rd_waddr;
			out.result <= rd_data;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write));

endmodule

`default_nettype wire

/* source/regfile.sv */
`default_nettype none

module regfile import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [REG_AW-1:0] raddr1,
	input logic [REG_AW-1:0] raddr2,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2,
	stage_bus.dst wb
);

	logic [XLEN-1:0] regs [0:31];
	logic wena;

	assign wena = wb.inst_valid & wb.rd_wena & (wb.rd_waddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wena) begin
			regs[wb.rd_waddr] <= wb.result;
		end
	end

	// write-through so ID sees the retiring value
	assign rdata1 = (raddr1 == '0) ? '0 :
		(wena && wb.rd_waddr == raddr1) ? wb.result : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(wena && wb.rd_waddr == raddr2) ? wb.result : regs[raddr2];

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int XLEN = 64;
	localparam int INST_W = 32;
	localparam int REG_AW = 5;

	localparam logic [XLEN-1:0] RESET_PC = '0;

	// addi x0, x0, 0
	localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic {
		OP2_REG,
		OP2_IMM
	} op2_sel_e;

	// funct3 values that the decoder accepts
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_DW = 3'b011;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

endpackage

`default_nettype wire

/* source/rvcpu.sv */
`default_nettype none

module rvcpu import rv_pkg::*; (
	input logic clk,
	input logic rst,

	input logic if_ready,
	input logic [XLEN-1:0] if_data_read,
	output logic if_valid,
	output logic [XLEN-1:0] if_addr,

	input logic mem_ready,
	input logic [XLEN-1:0] mem_data_read,
	output logic mem_valid,
	output logic mem_write,
	output logic [XLEN-1:0] mem_addr,
	output logic [XLEN-1:0] mem_data_write,

	output logic diff_wb_rd_wena,
	output logic [REG_AW-1:0] diff_wb_rd_waddr,
	output logic [XLEN-1:0] diff_wb_rd_data,
	output logic [XLEN-1:0] diff_wb_pc,
	output logic [INST_W-1:0] diff_wb_inst,
	output logic diff_wb_inst_valid
);

	stage_bus id_ex();
	stage_bus ex_me();
	stage_bus me_wb();

	logic [XLEN-1:0] id_pc;
	logic [INST_W-1:0] id_inst;
	logic id_inst_valid;
	logic [REG_AW-1:0] rs1_addr, rs2_addr;
	logic rs1_rena, rs2_rena;
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic redirect;
	logic [XLEN-1:0] target_pc;
	logic mem_busy;
	logic if_stall, id_stall, id_flush, ex_stall;

	if_stage u_if (
		.clk(clk), .rst(rst),
		.if_ready(if_ready), .if_data_read(if_data_read),
		.if_valid(if_valid), .if_addr(if_addr),
		.stall(if_stall), .redirect(redirect), .target_pc(target_pc),
		.pc(id_pc), .inst(id_inst), .inst_valid(id_inst_valid)
	);

	id_stage u_id (
		.clk(clk), .rst(rst), .stall(id_stall), .flush(id_flush),
		.pc(id_pc), .inst(id_inst), .inst_valid(id_inst_valid),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_rena(rs1_rena), .rs2_rena(rs2_rena),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.out(id_ex.src)
	);

	regfile u_rf (
		.clk(clk), .rst(rst),
		.raddr1(rs1_addr), .raddr2(rs2_addr),
		.rdata1(rs1_data), .rdata2(rs2_data),
		.wb(me_wb.dst)
	);

	hazard_unit u_hz (
		.rs1_addr(rs1_addr), .rs1_rena(rs1_rena),
		.rs2_addr(rs2_addr), .rs2_rena(rs2_rena),
		.ex(id_ex.dst), .redirect(redirect), .mem_busy(mem_busy),
		.if_stall(if_stall), .id_stall(id_stall), .id_flush(id_flush),
		.ex_stall(ex_stall), .me_stall()
	);

	exe_stage u_ex (
		.clk(clk), .rst(rst), .stall(ex_stall),
		.in(id_ex.dst), .me_fwd(ex_me.dst), .wb_fwd(me_wb.dst),
		.out(ex_me.src), .redirect(redirect), .target_pc(target_pc)
	);

	me_stage u_me (
		.clk(clk), .rst(rst), .in(ex_me.dst),
		.mem_valid(mem_valid), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_data_write(mem_data_write),
		.mem_ready(mem_ready), .mem_data_read(mem_data_read),
		.busy(mem_busy), .out(me_wb.src)
	);

	assign diff_wb_rd_wena = me_wb.rd_wena;
	assign diff_wb_rd_waddr = me_wb.rd_waddr;
	assign diff_wb_rd_data = me_wb.result;
	assign diff_wb_pc = me_wb.pc;
	assign diff_wb_inst = me_wb.inst;
	assign diff_wb_inst_valid = me_wb.inst_valid;

endmodule

`default_nettype wire

/* source/stage_bus.sv */
`default_nettype none

interface stage_bus import rv_pkg::*; ();

	logic [XLEN-1:0] pc;
	logic [INST_W-1:0] inst;
	logic inst_valid;

	logic rd_wena;
	logic [REG_AW-1:0] rd_waddr;

	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;

	logic [XLEN-1:0] imm;
	alu_op_e alu_op;
	op2_sel_e op2_sel;

	logic branch;
	logic branch_ne;
	logic jump;

	logic mem_rena;
	logic mem_wena;

	// alu result, store address, or final rd data after ME
	logic [XLEN-1:0] result;

	modport src (
		output pc, inst, inst_valid, rd_wena, rd_waddr,
		output rs1_addr, rs2_addr, rs1_data, rs2_data,
		output imm, alu_op, op2_sel, branch, branch_ne, jump,
		output mem_rena, mem_wena, result
	);

	modport dst (
		input pc, inst, inst_valid, rd_wena, rd_waddr,
		input rs1_addr, rs2_addr, rs1_data, rs2_data,
		input imm, alu_op, op2_sel, branch, branch_ne, jump,
		input mem_rena, mem_wena, result
	);

endinterface

`default_nettype wire

/* tb.f */
+incdir+verif
source/rv_pkg.sv
source/stage_bus.sv
source/if_stage.sv
source/id_stage.sv
source/regfile.sv
source/hazard_unit.sv
source/exe_stage.sv
source/me_stage.sv
source/rvcpu.sv
verif/tb_rvcpu.sv

/* verif/tb_iss.svh */
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

localparam int PROG_LEN = 202;
localparam int LOOP_IDX = PROG_LEN - 1;
localparam logic [XLEN-1:0] LOOP_PC = 64'(LOOP_IDX * 4);
localparam logic [XLEN-1:0] DATA_BASE = 64'h100;
localparam int DATA_WORDS = 32;
localparam logic [4:0] BASE_REG = 5'd8;
localparam logic [15:0] LFSR_SEED = 16'd48;

logic [15:0] lfsr;
logic [31:0] prog [0:PROG_LEN-1];
logic [XLEN-1:0] mregs [0:31];
logic [XLEN-1:0] mmem [0:DATA_WORDS-1];

// expected retirements and stores, in program order
logic [XLEN-1:0] exp_pc [$];
logic [31:0] exp_inst [$];
logic exp_wena [$];
logic [4:0] exp_rd [$];
logic [XLEN-1:0] exp_data [$];
logic [XLEN-1:0] exp_st_addr [$];
logic [XLEN-1:0] exp_st_data [$];

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_step(lfsr);
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
	return {addr[31:0] ^ ~addr[63:32], addr[31:0] ^ 32'h3c5a_96e1};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic build_program();
	logic [3:0] sel;
	logic [4:0] rd, rs1, rs2;
	logic [11:0] mofs;
	int k;
	lfsr = LFSR_SEED;
	// base register for every load and store
	prog[0] = enc_i(DATA_BASE[11:0], 5'd0, 3'b000, BASE_REG, OPC_OP_IMM);
	for (int i = 1; i < LOOP_IDX; i++) begin
		sel = 4'(rand_bits(4));
		rd = 5'(rand_bits(3));
		rs1 = 5'(rand_bits(3));
		rs2 = 5'(rand_bits(3));
		// 2 to 4 ahead, never past the final loop
		k = 2 + int'(rand_bits(2) % 3);
		if (i + k > LOOP_IDX)
			k = LOOP_IDX - i;
		case (sel)
			4'd0: prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
			4'd1: prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
			4'd2: prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
			4'd3: prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
			4'd4: prog[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
			4'd5: prog[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
			4'd8, 4'd9: begin
				mofs = 12'(rand_bits(5)) << 3;
				prog[i] = enc_i(mofs, BASE_REG, 3'b011, rd, OPC_LOAD);
			end
			4'd10, 4'd11: begin
				mofs = 12'(rand_bits(5)) << 3;
				prog[i] = enc_s(mofs, rs2, BASE_REG);
			end
			4'd12: prog[i] = enc_b(13'(k * 4), rs2, rs1, 3'b000);
			4'd13: prog[i] = enc_b(13'(k * 4), rs2, rs1, 3'b001);
			4'd14: prog[i] = enc_j(21'(k * 4), rd);
			default: prog[i] = enc_i(12'(rand_bits(12)), rs1, 3'b000, rd, OPC_OP_IMM);
		endcase
	end
	// jal x0, 0
	prog[LOOP_IDX] = enc_j(21'd0, 5'd0);
endtask

task automatic run_model();
	logic [XLEN-1:0] pc, next_pc, a, b, res, ea;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
	logic [31:0] w;
	logic wr, last;
	int j;
	for (j = 0; j < 32; j++)
		mregs[j] = '0;
	for (j = 0; j < DATA_WORDS; j++)
		mmem[j] = fill_word(DATA_BASE + 64'(8 * j));
	pc = RESET_PC;
	last = 1'b0;
	while (!last) begin
		w = prog[int'(pc >> 2)];
		a = mregs[w[19:15]];
		b = mregs[w[24:20]];
		imm_i = {{52{w[31]}}, w[31:20]};
		imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		wr = 1'b1;
		res = '0;
		next_pc = pc + 64'd4;
		case (w[6:0])
			OPC_OP: begin
				case (w[14:12])
					3'b000: res = w[30] ? a - b : a + b;
					3'b010: res = 64'($signed(a) < $signed(b));
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			OPC_LOAD: res = mmem[int'((a + imm_i - DATA_BASE) >> 3)];
			OPC_STORE: begin
				wr = 1'b0;
				ea = a + imm_s;
				exp_st_addr.push_back(ea);
				exp_st_data.push_back(b);
				mmem[int'((ea - DATA_BASE) >> 3)] = b;
			end
			OPC_BRANCH: begin
				wr = 1'b0;
				// funct3 bit 0 set means bne
				if ((a == b) != w[12])
					next_pc = pc + imm_b;
			end
			OPC_JAL: begin
				res = pc + 64'd4;
				next_pc = pc + imm_j;
			end
			default: res = a + imm_i;
		endcase
		exp_pc.push_back(pc);
		exp_inst.push_back(w);
		exp_wena.push_back(wr && w[11:7] != 5'd0);
		exp_rd.push_back(w[11:7]);
		exp_data.push_back(res);
		if (wr && w[11:7] != 5'd0)
			mregs[w[11:7]] = res;
		last = (pc == LOOP_PC);
		pc = next_pc;
	end
endtask

`endif

/* verif/tb_rvcpu.sv */
`default_nettype none

module tb_rvcpu import rv_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 200 * 16;

	logic clk;
	logic rst;
	logic if_ready;
	logic [XLEN-1:0] if_data_read;
	logic if_valid;
	logic [XLEN-1:0] if_addr;
	logic mem_ready;
	logic [XLEN-1:0] mem_data_read;
	logic mem_valid;
	logic mem_write;
	logic [XLEN-1:0] mem_addr;
	logic [XLEN-1:0] mem_data_write;
	logic diff_wb_rd_wena;
	logic [REG_AW-1:0] diff_wb_rd_waddr;
	logic [XLEN-1:0] diff_wb_rd_data;
	logic [XLEN-1:0] diff_wb_pc;
	logic [INST_W-1:0] diff_wb_inst;
	logic diff_wb_inst_valid;

	`include "tb_iss.svh"

	logic [XLEN-1:0] dmem [0:DATA_WORDS-1];
	logic fetch_pending, data_pending, fetch_seen, finished;
	logic [1:0] fetch_wait, data_wait;
	int cycles;

	rvcpu DUT (
		.clk(clk), .rst(rst),
		.if_ready(if_ready), .if_data_read(if_data_read),
		.if_valid(if_valid), .if_addr(if_addr),
		.mem_ready(mem_ready), .mem_data_read(mem_data_read),
		.mem_valid(mem_valid), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_data_write(mem_data_write),
		.diff_wb_rd_wena(diff_wb_rd_wena), .diff_wb_rd_waddr(diff_wb_rd_waddr),
		.diff_wb_rd_data(diff_wb_rd_data), .diff_wb_pc(diff_wb_pc),
		.diff_wb_inst(diff_wb_inst), .diff_wb_inst_valid(diff_wb_inst_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] imem_word(input logic [XLEN-1:0] idx);
		return (idx < PROG_LEN) ? prog[int'(idx)] : NOP_INST;
	endfunction

	task automatic serve_fetch();
		logic [XLEN-1:0] dw;
		if_ready = 1'b0;
		if (if_valid === 1'b1) begin
			if (!fetch_seen) begin
				check_value("if_addr", if_addr, RESET_PC);
				fetch_seen = 1'b1;
			end
			if (!fetch_pending) begin
				fetch_pending = 1'b1;
				fetch_wait = 2'(rand_bits(2));
			end
			if (fetch_wait == 2'd0) begin
				// two instructions per doubleword, low word first
				dw = if_addr >> 3;
				if_data_read = {imem_word(2 * dw + 1), imem_word(2 * dw)};
				if_ready = 1'b1;
				fetch_pending = 1'b0;
			end else begin
				fetch_wait = fetch_wait - 2'd1;
			end
		end
	endtask

	task automatic serve_data();
		logic [XLEN-1:0] st_addr, st_data;
		int idx;
		mem_ready = 1'b0;
		if (mem_valid === 1'b1) begin
			if (!data_pending) begin
				data_pending = 1'b1;
				data_wait = 2'(rand_bits(2));
			end
			if (data_wait == 2'd0) begin
				if (mem_addr < DATA_BASE || mem_addr >= DATA_BASE + 64'(8 * DATA_WORDS) ||
						mem_addr[2:0] != 3'd0) begin
					$display("data access at %h falls outside the data region", mem_addr);
					abort_run();
				end
				idx = int'((mem_addr - DATA_BASE) >> 3);
				if (mem_write) begin
					if (exp_st_addr.size() == 0) begin
						$display("store to %h that the program never makes", mem_addr);
						abort_run();
					end
					st_addr = exp_st_addr.pop_front();
					st_data = exp_st_data.pop_front();
					check_value("mem_addr", mem_addr, st_addr);
					check_value("mem_data_write", mem_data_write, st_data);
					dmem[idx] = mem_data_write;
				end else begin
					mem_data_read = dmem[idx];
				end
				mem_ready = 1'b1;
				data_pending = 1'b0;
			end else begin
				data_wait = data_wait - 2'd1;
			end
		end
	endtask

	// fetch side draws its delay before the data side
	always @(negedge clk) begin
		serve_fetch();
		serve_data();
	end

	task automatic check_retire();
		logic [XLEN-1:0] e_pc, e_data;
		logic [31:0] e_inst;
		logic [4:0] e_rd;
		logic e_wena;
		if (exp_pc.size() == 0) begin
			$display("instruction at pc %h retired after the program ended", diff_wb_pc);
			abort_run();
		end
		e_pc = exp_pc.pop_front();
		e_inst = exp_inst.pop_front();
		e_wena = exp_wena.pop_front();
		e_rd = exp_rd.pop_front();
		e_data = exp_data.pop_front();
		check_value("diff_wb_pc", diff_wb_pc, e_pc);
		check_value("diff_wb_inst", 64'(diff_wb_inst), 64'(e_inst));
		check_value("diff_wb_rd_wena", 64'(diff_wb_rd_wena), 64'(e_wena));
		if (e_wena) begin
			check_value("diff_wb_rd_waddr", 64'(diff_wb_rd_waddr), 64'(e_rd));
			check_value("diff_wb_rd_data", diff_wb_rd_data, e_data);
		end
		finished = (e_pc == LOOP_PC);
	endtask

	always @(negedge clk) begin
		if (!rst && !finished && diff_wb_inst_valid === 1'b1)
			check_retire();
	end

	always @(negedge clk) begin
		if (!rst && !finished) begin
			cycles = cycles + 1;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout, the program did not finish within %0d cycles",
					TIMEOUT_CYCLES);
				abort_run();
			end
		end
	end

	initial begin
		int j;
		rst = 1'b1;
		if_ready = 1'b0;
		if_data_read = '0;
		mem_ready = 1'b0;
		mem_data_read = '0;
		fetch_pending = 1'b0;
		data_pending = 1'b0;
		fetch_wait = 2'd0;
		data_wait = 2'd0;
		fetch_seen = 1'b0;
		finished = 1'b0;
		cycles = 0;
		build_program();
		run_model();
		for (j = 0; j < DATA_WORDS; j++)
			dmem[j] = fill_word(DATA_BASE + 64'(8 * j));
		repeat (5) begin
			@(negedge clk);
			check_value("if_valid", 64'(if_valid), 64'd0);
			check_value("mem_valid", 64'(mem_valid), 64'd0);
			check_value("diff_wb_inst_valid", 64'(diff_wb_inst_valid), 64'd0);
		end
		rst = 1'b0;
		wait (finished);
		if (exp_st_addr.size() != 0) begin
			$display("%0d expected stores never reached the data bus", exp_st_addr.size());
			abort_run();
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire
